//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module basic_organ_tb -o basic_organ_sim
	out=$$(./obj_dir/basic_organ_sim); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- dv/basic_organ_tb.sv
`timescale 1ns/1ps

module basic_organ_tb
  import organ_pkg::*;
;

  logic         CLK_50M = 1'b0;
  logic         rst_n;
  switch_bank_t switches;
  key_bank_t    keys;
  logic         tone;
  sample_t      sample;
  label_t       note_text;
  period_t      sample_period;
  hex_bank_t    hex;
  int           seed = 37618;

  basic_organ #(
    .tick_cycles    (50),
    .refresh_cycles (2000)
  ) basic_organ_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .switches      (switches),
    .keys          (keys),
    .tone          (tone),
    .sample        (sample),
    .note_text     (note_text),
    .sample_period (sample_period),
    .hex           (hex)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ==================================================
  // Reference model
  // ==================================================
  function automatic half_period_t half_period_of(input note_sel_t note);
    case (note)
      3'd0: return 26'd95602;
      3'd1: return 26'd85179;
      3'd2: return 26'd75873;
      3'd3: return 26'd71633;
      3'd4: return 26'd63857;
      3'd5: return 26'd56818;
      3'd6: return 26'd50659;
      default: return 26'd47801;
    endcase
  endfunction

  function automatic label_t label_of(input switch_bank_t sw);
    if (!sw.enable)
      return "OFF";
    case (sw.note)
      3'd0: return "Do ";
      3'd1: return "Re ";
      3'd2: return "Mi ";
      3'd3: return "Fa ";
      3'd4: return "So ";
      3'd5: return "La ";
      3'd6: return "Ti ";
      default: return "DO2";
    endcase
  endfunction

  // Lit segments as gfedcba inverted for the active-low outputs
  function automatic seg_t seg_of_nibble(input logic [3:0] nibble);
    logic [6:0] lit [0:15] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                              7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    return ~lit[nibble];
  endfunction

  function automatic hex_bank_t hex_of_period(input period_t value);
    return {seg_of_nibble(4'h0), seg_of_nibble(4'h0),
            seg_of_nibble(value[15:12]), seg_of_nibble(value[11:8]),
            seg_of_nibble(value[7:4]), seg_of_nibble(value[3:0])};
  endfunction

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_tone(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_half_period(input string name, input half_period_t exp,
                                   input half_period_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_label(input string name, input label_t exp, input label_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected \"%s\" actual \"%s\"", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_period(input string name, input period_t exp, input period_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_hex(input string name, input hex_bank_t exp, input hex_bank_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  // ==================================================
  // Waits with timeouts
  // ==================================================
  task automatic wait_toggle(input int limit, output int cycles);
    logic start;
    start = tone;
    cycles = 0;
    while (tone == start && cycles < limit)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (tone == start)
    begin
      $display("Timeout at %0t: tone never toggled", $time);
      stop_run();
    end
  endtask

  task automatic hold_key_until_change(input key_bank_t held, input int limit, input string what);
    period_t start;
    int      cycles;
    start = sample_period;
    cycles = 0;
    @(posedge CLK_50M);
    keys <= held;
    while (sample_period == start && cycles < limit)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (sample_period == start)
    begin
      $display("Timeout at %0t: sample_period never changed while %s was held", $time, what);
      stop_run();
    end
    @(posedge CLK_50M);
    keys <= '1;
  endtask

  // Sample and label follow tone and switches on every cycle
  always @(negedge CLK_50M)
  begin
    if (rst_n)
    begin
      check_sample("sample", tone ? 8'sh7F : 8'sh80, sample);
      check_label("note_text", label_of(switches), note_text);
    end
  end

  initial
  begin
    int           rnd;
    int           cycles;
    switch_bank_t sw;
    rst_n = 1'b0;
    switches = '0;
    keys = '1;
    repeat (2) @(posedge CLK_50M);
    rst_n <= 1'b1;
    repeat (2) @(negedge CLK_50M);
    check_tone("tone", 1'b0, tone);
    check_sample("sample", 8'sh80, sample);
    check_period("sample_period", 16'd12499, sample_period);
    check_hex("hex", hex_of_period(16'h0000), hex);

    for (int i = 0; i < 6; i++)
    begin
      rnd = $random(seed);
      sw.enable = 1'b1;
      sw.note = rnd[2:0];
      @(posedge CLK_50M);
      switches <= sw;
      repeat (2) @(negedge CLK_50M);
      wait_toggle(200000, cycles);
      wait_toggle(200000, cycles);
      check_half_period("tone half period", half_period_of(sw.note), half_period_t'(cycles));
    end

    // Sound off for one slow half wave
    // Fastest note stays selected so a running divider would toggle in the window
    sw.enable = 1'b0;
    sw.note = 3'd7;
    @(posedge CLK_50M);
    switches <= sw;
    @(negedge CLK_50M);
    check_label("note_text", "OFF", note_text);
    repeat (int'(half_period_of(3'd0)))
    begin
      @(negedge CLK_50M);
      check_tone("tone", 1'b0, tone);
    end
    for (int n = 0; n < 8; n++)
    begin
      sw.enable = 1'b1;
      sw.note = note_sel_t'(n);
      @(posedge CLK_50M);
      switches <= sw;
      @(negedge CLK_50M);
      check_label("note_text", label_of(sw), note_text);
    end

    hold_key_until_change(3'b011, 12000, "up");
    check_period("sample_period", 16'd12599, sample_period);
    hold_key_until_change(3'b101, 12000, "down");
    check_period("sample_period", 16'd12499, sample_period);
    hold_key_until_change(3'b101, 12000, "down");
    check_period("sample_period", 16'd12399, sample_period);

    hold_key_until_change(3'b110, 8, "reset");
    check_period("sample_period", 16'd12499, sample_period);
    repeat (2001) @(negedge CLK_50M);
    check_hex("hex", hex_of_period(16'd12499), hex);

    $display("Test passed");
    $finish;
  end

endmodule

//--- source/basic_organ.sv
`timescale 1ns/1ps

module basic_organ
  import organ_pkg::*;
#(
  parameter int tick_cycles = TICK_CYCLES_DEFAULT,
  parameter int refresh_cycles = REFRESH_CYCLES_DEFAULT
)
(
  input  logic         CLK_50M,
  input  logic         rst_n,
  input  switch_bank_t switches,
  input  key_bank_t    keys,
  output logic         tone,
  output sample_t      sample,
  output label_t       note_text,
  output period_t      sample_period,
  output hex_bank_t    hex
);

  // ==================================================
  // Tone path
  // ==================================================
  tone_generator tone_generator_i (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .switches (switches),
    .tone     (tone),
    .sample   (sample)
  );

  note_label note_label_i (
    .switches (switches),
    .text     (note_text)
  );

  // ==================================================
  // Speed keys and period display
  // ==================================================
  speed_control #(
    .tick_cycles (tick_cycles)
  ) speed_control_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .keys          (keys),
    .sample_period (sample_period)
  );

  hex_display #(
    .refresh_cycles (refresh_cycles)
  ) hex_display_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .sample_period (sample_period),
    .hex           (hex)
  );

endmodule

//--- source/hex_display.sv
`timescale 1ns/1ps

module hex_display
  import organ_pkg::*;
#(
  parameter int refresh_cycles = REFRESH_CYCLES_DEFAULT
)
(
  input  logic      CLK_50M,
  input  logic      rst_n,
  input  period_t   sample_period,
  output hex_bank_t hex
);

  refresh_cnt_t refresh_cnt;
  logic         refresh;
  period_t      shown;

  // Active-low segments, g down to a
  function automatic seg_t hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0: hex_to_seg = 7'b1000000;
      4'h1: hex_to_seg = 7'b1111001;
      4'h2: hex_to_seg = 7'b0100100;
      4'h3: hex_to_seg = 7'b0110000;
      4'h4: hex_to_seg = 7'b0011001;
      4'h5: hex_to_seg = 7'b0010010;
      4'h6: hex_to_seg = 7'b0000010;
      4'h7: hex_to_seg = 7'b1111000;
      4'h8: hex_to_seg = 7'b0000000;
      4'h9: hex_to_seg = 7'b0010000;
      4'hA: hex_to_seg = 7'b0001000;
      4'hB: hex_to_seg = 7'b0000011;
      4'hC: hex_to_seg = 7'b1000110;
      4'hD: hex_to_seg = 7'b0100001;
      4'hE: hex_to_seg = 7'b0000110;
      default: hex_to_seg = 7'b0001110;
    endcase
  endfunction

  // 2 Hz refresh strobe
  assign refresh = (refresh_cnt == refresh_cnt_t'(refresh_cycles - 1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      shown <= '0;
    end
    else
    begin
      refresh_cnt <= refresh ? '0 : refresh_cnt + 25'd1;
      if (refresh)
        shown <= sample_period;
    end
  end

  // Period fills the low four digits only
  assign hex.hex5 = hex_to_seg(4'h0);
  assign hex.hex4 = hex_to_seg(4'h0);
  assign hex.hex3 = hex_to_seg(shown[15:12]);
  assign hex.hex2 = hex_to_seg(shown[11:8]);
  assign hex.hex1 = hex_to_seg(shown[7:4]);
  assign hex.hex0 = hex_to_seg(shown[3:0]);

endmodule

//--- source/note_label.sv
`timescale 1ns/1ps

module note_label
  import organ_pkg::*;
(
  input  switch_bank_t switches,
  output label_t       text
);

  // Solfege names, padded with a space to three characters
  always_comb
  begin
    if (!switches.enable)
    begin
      text = {CHAR_O, CHAR_F, CHAR_F};
    end
    else
    begin
      case (switches.note)
        3'd0: text = {CHAR_D, CHAR_LC_O, CHAR_SPACE};
        3'd1: text = {CHAR_R, CHAR_LC_E, CHAR_SPACE};
        3'd2: text = {CHAR_M, CHAR_LC_I, CHAR_SPACE};
        3'd3: text = {CHAR_F, CHAR_LC_A, CHAR_SPACE};
        3'd4: text = {CHAR_S, CHAR_LC_O, CHAR_SPACE};
        3'd5: text = {CHAR_L, CHAR_LC_A, CHAR_SPACE};
        3'd6: text = {CHAR_T, CHAR_LC_I, CHAR_SPACE};
        // High Do, one octave up
        default: text = {CHAR_D, CHAR_O, CHAR_TWO};
      endcase
    end
  end

endmodule

//--- source/organ_pkg.sv
package organ_pkg;

  // ==================================================
  // Widths with a meaning
  // ==================================================
  typedef logic [2:0] note_sel_t;
  typedef logic [25:0] half_period_t;
  typedef logic signed [7:0] sample_t;
  typedef logic [7:0] char_t;
  typedef char_t [2:0] label_t;
  typedef logic signed [15:0] speed_t;
  typedef logic [15:0] period_t;
  typedef logic [6:0] seg_t;

  // Counters for the clock-enable strobes
  typedef logic [15:0] tick_cnt_t;
  typedef logic [24:0] refresh_cnt_t;
  typedef logic [6:0] step_cnt_t;

  // Half periods in 50 MHz cycles, Do up to high Do
  localparam half_period_t NOTE_HALF_PERIOD [0:7] = '{
    26'd95602, 26'd85179, 26'd75873, 26'd71633,
    26'd63857, 26'd56818, 26'd50659, 26'd47801
  };

  // Full-scale square wave levels
  localparam sample_t SAMPLE_HIGH = 8'sh7F;
  localparam sample_t SAMPLE_LOW = 8'sh80;

  // ASCII codes for the note names
  localparam char_t CHAR_D = 8'h44;
  localparam char_t CHAR_R = 8'h52;
  localparam char_t CHAR_M = 8'h4D;
  localparam char_t CHAR_F = 8'h46;
  localparam char_t CHAR_S = 8'h53;
  localparam char_t CHAR_L = 8'h4C;
  localparam char_t CHAR_T = 8'h54;
  localparam char_t CHAR_O = 8'h4F;
  localparam char_t CHAR_LC_O = 8'h6F;
  localparam char_t CHAR_LC_E = 8'h65;
  localparam char_t CHAR_LC_I = 8'h69;
  localparam char_t CHAR_LC_A = 8'h61;
  localparam char_t CHAR_TWO = 8'h32;
  localparam char_t CHAR_SPACE = 8'h20;

  // ==================================================
  // Speed control and display
  // ==================================================
  localparam speed_t SPEED_STEP = 16'sd100;
  localparam period_t DEFAULT_PERIOD = 16'd12499;
  localparam int STEPS_PER_SEC = 10;
  localparam int TICKS_PER_STEP = 1000 / STEPS_PER_SEC;
  localparam int TICK_CYCLES_DEFAULT = 50000;
  localparam int REFRESH_CYCLES_DEFAULT = 25000000;

  typedef struct packed {
    logic enable;
    note_sel_t note;
  } switch_bank_t;

  // All keys active low
  typedef struct packed {
    logic up_n;
    logic down_n;
    logic reset_n;
  } key_bank_t;

  typedef struct packed {
    seg_t hex5;
    seg_t hex4;
    seg_t hex3;
    seg_t hex2;
    seg_t hex1;
    seg_t hex0;
  } hex_bank_t;

endpackage

//--- source/speed_control.sv
`timescale 1ns/1ps

module speed_control
  import organ_pkg::*;
#(
  parameter int tick_cycles = TICK_CYCLES_DEFAULT
)
(
  input  logic      CLK_50M,
  input  logic      rst_n,
  input  key_bank_t keys,
  output period_t   sample_period
);

  key_bank_t keys_meta;
  key_bank_t keys_sync;
  tick_cnt_t tick_cnt;
  step_cnt_t step_cnt;
  logic      tick;
  logic      step_now;
  speed_t    speed;

  // ==================================================
  // Key synchronisers
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // Released keys read high
      keys_meta <= '1;
      keys_sync <= '1;
    end
    else
    begin
      keys_meta <= keys;
      keys_sync <= keys_meta;
    end
  end

  // ==================================================
  // 1 kHz tick and step window
  // ==================================================
  assign tick = (tick_cnt == tick_cnt_t'(tick_cycles - 1));
  assign step_now = tick && (step_cnt == step_cnt_t'(TICKS_PER_STEP - 1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
      step_cnt <= '0;
    end
    else
    begin
      tick_cnt <= tick ? '0 : tick_cnt + 16'd1;
      if (tick)
      begin
        step_cnt <= step_now ? '0 : step_cnt + 7'd1;
      end
    end
  end

  // Speed register, reset key first, then up over down
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      speed <= '0;
      sample_period <= DEFAULT_PERIOD;
    end
    else
    begin
      if (!keys_sync.reset_n)
      begin
        speed <= '0;
      end
      else if (step_now && !keys_sync.up_n)
      begin
        speed <= speed + SPEED_STEP;
      end
      else if (step_now && !keys_sync.down_n)
      begin
        speed <= speed - SPEED_STEP;
      end
      // Two's complement wrap gives default plus signed speed
      sample_period <= period_t'(DEFAULT_PERIOD + $unsigned(speed));
    end
  end

endmodule

//--- source/tone_generator.sv
`timescale 1ns/1ps

module tone_generator
  import organ_pkg::*;
(
  input  logic         CLK_50M,
  input  logic         rst_n,
  input  switch_bank_t switches,
  output logic         tone,
  output sample_t      sample
);

  switch_bank_t prev_switches;
  half_period_t half_period;
  half_period_t count;
  logic         restart;
  logic         wrap;

  always_comb
  begin
    half_period = NOTE_HALF_PERIOD[switches.note];
    // Any switch change starts the wave over from low
    restart = (switches != prev_switches);
    wrap = (count == half_period - 26'd1);
  end

  // ==================================================
  // Divider counter and wave
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prev_switches <= '0;
      count <= '0;
      tone <= 1'b0;
      sample <= SAMPLE_LOW;
    end
    else
    begin
      prev_switches <= switches;
      if (restart || !switches.enable)
      begin
        count <= '0;
        tone <= 1'b0;
        sample <= SAMPLE_LOW;
      end
      else if (wrap)
      begin
        count <= '0;
        tone <= ~tone;
        sample <= tone ? SAMPLE_LOW : SAMPLE_HIGH;
      end
      else
      begin
        count <= count + 26'd1;
      end
    end
  end

endmodule

//--- sources.f
source/organ_pkg.sv
source/tone_generator.sv
source/note_label.sv
source/speed_control.sv
source/hex_display.sv
source/basic_organ.sv
dv/basic_organ_tb.sv
